//--- rtl/blob_pkg.sv
// Shared constants and pixel types for the color blob detector.
// Import into any block that needs frame geometry or the RGB565 layout.
`default_nettype none

package blob_pkg;

	// ==============================
	// Frame geometry
	// ==============================
	localparam int FRAME_W = 16;     // Pixels per line.
	localparam int FRAME_H = 12;     // Lines per frame.
	localparam int COORD_W = 4;      // Width of one x or y coordinate.
	localparam int COUNT_W = 8;      // Holds up to 192 pixels of a frame.

	// ==============================
	// Color windows
	// ==============================
	localparam int NUM_COLORS  = 5;
	localparam int COLOR_IDX_W = 3;

	localparam logic [COLOR_IDX_W-1:0] COLOR_RED    = 3'd0;
	localparam logic [COLOR_IDX_W-1:0] COLOR_GREEN  = 3'd1;
	localparam logic [COLOR_IDX_W-1:0] COLOR_ORANGE = 3'd2;
	localparam logic [COLOR_IDX_W-1:0] COLOR_YELLOW = 3'd3;
	localparam logic [COLOR_IDX_W-1:0] COLOR_PURPLE = 3'd4;

	// Frame sequencer state codes.
	localparam int SEQ_STATE_W = 2;
	localparam logic [SEQ_STATE_W-1:0] ST_IDLE   = 2'd0;
	localparam logic [SEQ_STATE_W-1:0] ST_ACTIVE = 2'd1;
	localparam logic [SEQ_STATE_W-1:0] ST_DRAIN  = 2'd2;
	localparam logic [SEQ_STATE_W-1:0] ST_REPORT = 2'd3;

	// RGB565, red in the top bits.
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// Pixels and threshold words, seen as a raw word or as fields.
	typedef union packed {
		logic [15:0] raw;
		rgb565_t     rgb;
	} pixel_u;

endpackage

`default_nettype wire

//--- rtl/pixel_tag_if.sv
// One classified pixel, passed from the threshold stage to the region tracker.
`timescale 1ns/1ps
`default_nettype none

interface pixel_tag_if import blob_pkg::*; ();

	logic                  valid;   // Tag holds an accepted pixel.
	logic [COORD_W-1:0]    x;
	logic [COORD_W-1:0]    y;
	logic [NUM_COLORS-1:0] hits;    // One bit per color index.

	modport source (
		output valid, x, y, hits
	);

	modport sink (
		input valid, x, y, hits
	);

endinterface

`default_nettype wire

//--- rtl/color_thresholds.sv
// Classifies each accepted pixel against the five programmable color windows.
// The result is registered, so the tag follows the pixel by one cycle.
`timescale 1ns/1ps
`default_nettype none

module color_thresholds import blob_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  pixel_u                  pixel,
	input  pixel_u [NUM_COLORS-1:0] thresh_high,
	input  pixel_u [NUM_COLORS-1:0] thresh_low,
	input  logic                    accepted,
	input  logic [COORD_W-1:0]      x,
	input  logic [COORD_W-1:0]      y,
	pixel_tag_if.source             tag
);

	rgb565_t               px;
	logic [NUM_COLORS-1:0] hits;

	assign px = pixel.rgb;

	// ==============================
	// Window compare
	// ==============================
	always_comb begin : classify
		rgb565_t hi;
		rgb565_t lo;
		for (int c = 0; c < NUM_COLORS; c++) begin
			hi = thresh_high[c].rgb;
			lo = thresh_low[c].rgb;
			// Limits are inclusive on every field.
			hits[c] = (px.r >= lo.r) && (px.r <= hi.r)
				&& (px.g >= lo.g) && (px.g <= hi.g)
				&& (px.b >= lo.b) && (px.b <= hi.b);
		end
	end

	// ==============================
	// Tag register
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			tag.valid <= 1'b0;
		end else begin
			tag.valid <= accepted;
		end
		tag.x    <= x;          // Position of the pixel.
		tag.y    <= y;
		tag.hits <= hits;
	end

endmodule

`default_nettype wire

//--- rtl/pixel_position_counter.sv
// Tracks the raster position of accepted pixels within the open frame.
// Flags the last pixel so the sequencer can close the frame.
`timescale 1ns/1ps
`default_nettype none

module pixel_position_counter import blob_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               clear,
	input  logic               frame_active,
	input  logic               pixel_valid,
	output logic               accepted,
	output logic [COORD_W-1:0] x,
	output logic [COORD_W-1:0] y,
	output logic               frame_done
);

	logic last_x;
	logic last_y;

	// Strobes outside an open frame are dropped here.
	assign accepted = pixel_valid && frame_active;

	assign last_x     = (x == COORD_W'(FRAME_W - 1));
	assign last_y     = (y == COORD_W'(FRAME_H - 1));
	assign frame_done = accepted && last_x && last_y;

	always_ff @(posedge clk) begin
		if (rst || clear) begin
			x <= '0;
			y <= '0;
		end else if (accepted) begin
			if (last_x) begin
				x <= '0;            // End of line.
				if (last_y) begin
					y <= '0;
				end else begin
					y <= y + COORD_W'(1);
				end
			end else begin
				x <= x + COORD_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/frame_sequencer.sv
// Frame control FSM: opens a frame on sof, lets the last tag land,
// then steps through the five color results one per cycle.
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import blob_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   sof,
	input  logic                   frame_done,
	output logic                   frame_active,
	output logic                   clear,
	output logic                   report_en,
	output logic [COLOR_IDX_W-1:0] report_idx,
	output logic                   frame_busy
);

	logic [SEQ_STATE_W-1:0] state;
	logic [SEQ_STATE_W-1:0] state_next;
	logic                   last_report;

	assign frame_active = (state == ST_ACTIVE);
	assign clear        = (state == ST_IDLE) && sof;   // Only an idle sof opens a frame.
	assign report_en    = (state == ST_REPORT);
	assign frame_busy   = (state != ST_IDLE);
	assign last_report  = report_en && (report_idx == COLOR_IDX_W'(NUM_COLORS - 1));

	// ==============================
	// Next state
	// ==============================
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (sof) begin
					state_next = ST_ACTIVE;
				end
			end
			ST_ACTIVE: begin
				if (frame_done) begin
					state_next = ST_DRAIN;
				end
			end
			ST_DRAIN: begin
				state_next = ST_REPORT;     // Last tag reaches the tracker here.
			end
			ST_REPORT: begin
				if (last_report) begin
					state_next = ST_IDLE;
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// ==============================
	// Registers
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Report index runs 0 to NUM_COLORS-1 while reporting.
	always_ff @(posedge clk) begin
		if (rst || !report_en) begin
			report_idx <= '0;
		end else begin
			report_idx <= report_idx + COLOR_IDX_W'(1);
		end
	end

endmodule

`default_nettype wire

//--- rtl/color_region_tracker.sv
// Per-color pixel counts and bounding boxes over one frame.
// The read-out is selected combinationally by report_idx.
`timescale 1ns/1ps
`default_nettype none

module color_region_tracker import blob_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   clear,
	pixel_tag_if.sink              tag,
	input  logic [COLOR_IDX_W-1:0] report_idx,
	output logic [COUNT_W-1:0]     result_count,
	output logic [COORD_W-1:0]     result_x_min,
	output logic [COORD_W-1:0]     result_x_max,
	output logic [COORD_W-1:0]     result_y_min,
	output logic [COORD_W-1:0]     result_y_max
);

	logic [COUNT_W-1:0] count [NUM_COLORS];
	logic [COORD_W-1:0] x_min [NUM_COLORS];
	logic [COORD_W-1:0] x_max [NUM_COLORS];
	logic [COORD_W-1:0] y_min [NUM_COLORS];
	logic [COORD_W-1:0] y_max [NUM_COLORS];

	// ==============================
	// Accumulate
	// ==============================
	always_ff @(posedge clk) begin
		for (int c = 0; c < NUM_COLORS; c++) begin
			if (rst || clear) begin
				count[c] <= '0;
				x_min[c] <= '1;     // Empty box: min above max.
				x_max[c] <= '0;
				y_min[c] <= '1;
				y_max[c] <= '0;
			end else if (tag.valid && tag.hits[c]) begin
				count[c] <= count[c] + COUNT_W'(1);
				if (tag.x < x_min[c]) begin
					x_min[c] <= tag.x;
				end
				if (tag.x > x_max[c]) begin
					x_max[c] <= tag.x;
				end
				if (tag.y < y_min[c]) begin
					y_min[c] <= tag.y;
				end
				if (tag.y > y_max[c]) begin
					y_max[c] <= tag.y;
				end
			end
		end
	end

	// ==============================
	// Read-out
	// ==============================
	assign result_count = count[report_idx];
	assign result_x_min = x_min[report_idx];
	assign result_x_max = x_max[report_idx];
	assign result_y_min = y_min[report_idx];
	assign result_y_max = y_max[report_idx];

endmodule

`default_nettype wire

//--- rtl/color_blob_detector.sv
// Top level of the RGB565 color blob detector.
// Takes one frame of pixels and reports count and box for each color window.
`timescale 1ns/1ps
`default_nettype none

module color_blob_detector import blob_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         sof,
	input  logic                         pixel_valid,
	input  logic [15:0]                  pixel,
	input  logic [NUM_COLORS-1:0][15:0]  thresh_high,  // Indexed by color.
	input  logic [NUM_COLORS-1:0][15:0]  thresh_low,
	output logic                         frame_busy,
	output logic                         result_valid,
	output logic [COLOR_IDX_W-1:0]       result_color,
	output logic [COUNT_W-1:0]           result_count,
	output logic [COORD_W-1:0]           result_x_min,
	output logic [COORD_W-1:0]           result_x_max,
	output logic [COORD_W-1:0]           result_y_min,
	output logic [COORD_W-1:0]           result_y_max
);

	logic               frame_active;
	logic               clear;
	logic               frame_done;
	logic               accepted;
	logic [COORD_W-1:0] pix_x;
	logic [COORD_W-1:0] pix_y;

	pixel_tag_if tag_if ();

	frame_sequencer u_sequencer (
		.clk          (clk),
		.rst          (rst),
		.sof          (sof),
		.frame_done   (frame_done),
		.frame_active (frame_active),
		.clear        (clear),
		.report_en    (result_valid),
		.report_idx   (result_color),    // Also selects the tracker read-out.
		.frame_busy   (frame_busy)
	);

	pixel_position_counter u_position (
		.clk          (clk),
		.rst          (rst),
		.clear        (clear),
		.frame_active (frame_active),
		.pixel_valid  (pixel_valid),
		.accepted     (accepted),
		.x            (pix_x),
		.y            (pix_y),
		.frame_done   (frame_done)
	);

	color_thresholds u_thresholds (
		.clk         (clk),
		.rst         (rst),
		.pixel       (pixel),
		.thresh_high (thresh_high),
		.thresh_low  (thresh_low),
		.accepted    (accepted),
		.x           (pix_x),
		.y           (pix_y),
		.tag         (tag_if.source)
	);

	color_region_tracker u_tracker (
		.clk          (clk),
		.rst          (rst),
		.clear        (clear),
		.tag          (tag_if.sink),
		.report_idx   (result_color),
		.result_count (result_count),
		.result_x_min (result_x_min),
		.result_x_max (result_x_max),
		.result_y_min (result_y_min),
		.result_y_max (result_y_max)
	);

endmodule

`default_nettype wire

//--- verif/tb_color_blob_detector.sv
// Random-stimulus testbench for the color blob detector.
// Each frame gets new windows and pixels; every report is checked against a model.
`timescale 1ns/1ps
`default_nettype none

module tb_color_blob_detector import blob_pkg::*; ();

	localparam int NUM_FRAMES  = 6;
	localparam int FRAME_PIX   = FRAME_W * FRAME_H;
	localparam int CYCLE_LIMIT = NUM_FRAMES * (FRAME_PIX * 2 + 50);

	logic                        clk;
	logic                        rst;
	logic                        sof;
	logic                        pixel_valid;
	logic [15:0]                 pixel;
	logic [NUM_COLORS-1:0][15:0] thresh_high;
	logic [NUM_COLORS-1:0][15:0] thresh_low;
	logic                        frame_busy;
	logic                        result_valid;
	logic [COLOR_IDX_W-1:0]      result_color;
	logic [COUNT_W-1:0]          result_count;
	logic [COORD_W-1:0]          result_x_min;
	logic [COORD_W-1:0]          result_x_max;
	logic [COORD_W-1:0]          result_y_min;
	logic [COORD_W-1:0]          result_y_max;

	integer seed;
	int     cycle = 0;
	int     drv_errors = 0;
	int     mon_errors = 0;
	int     results_checked = 0;
	int     frames_reported = 0;
	int     rep_idx = 0;
	int     last_pix_cycle = 0;

	// Reference model with one entry per color.
	logic [COUNT_W-1:0] exp_count [NUM_COLORS];
	logic [COORD_W-1:0] exp_x_min [NUM_COLORS];
	logic [COORD_W-1:0] exp_x_max [NUM_COLORS];
	logic [COORD_W-1:0] exp_y_min [NUM_COLORS];
	logic [COORD_W-1:0] exp_y_max [NUM_COLORS];

	color_blob_detector dut (
		.clk          (clk),
		.rst          (rst),
		.sof          (sof),
		.pixel_valid  (pixel_valid),
		.pixel        (pixel),
		.thresh_high  (thresh_high),
		.thresh_low   (thresh_low),
		.frame_busy   (frame_busy),
		.result_valid (result_valid),
		.result_color (result_color),
		.result_count (result_count),
		.result_x_min (result_x_min),
		.result_x_max (result_x_max),
		.result_y_min (result_y_min),
		.result_y_max (result_y_max)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout: the frames did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ==============================
	// Model
	// ==============================
	function automatic logic in_window(input logic [15:0] p, input logic [15:0] lo,
			input logic [15:0] hi);
		return (p[15:11] >= lo[15:11]) && (p[15:11] <= hi[15:11])   // Red.
			&& (p[10:5] >= lo[10:5]) && (p[10:5] <= hi[10:5])       // Green.
			&& (p[4:0] >= lo[4:0]) && (p[4:0] <= hi[4:0]);          // Blue.
	endfunction

	task automatic model_clear();
		for (int c = 0; c < NUM_COLORS; c++) begin
			exp_count[c] = '0;
			exp_x_min[c] = '1;
			exp_x_max[c] = '0;
			exp_y_min[c] = '1;
			exp_y_max[c] = '0;
		end
	endtask

	task automatic model_pixel(input logic [15:0] p, input logic [COORD_W-1:0] x,
			input logic [COORD_W-1:0] y);
		for (int c = 0; c < NUM_COLORS; c++) begin
			if (in_window(p, thresh_low[c], thresh_high[c])) begin
				exp_count[c] = exp_count[c] + COUNT_W'(1);
				if (x < exp_x_min[c]) exp_x_min[c] = x;
				if (x > exp_x_max[c]) exp_x_max[c] = x;
				if (y < exp_y_min[c]) exp_y_min[c] = y;
				if (y > exp_y_max[c]) exp_y_max[c] = y;
			end
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
	endtask

	task automatic draw_window(input int c);
		logic [4:0] r0;
		logic [4:0] r1;
		logic [5:0] g0;
		logic [5:0] g1;
		logic [4:0] b0;
		logic [4:0] b1;
		r0 = 5'($random(seed));
		r1 = 5'($random(seed));
		g0 = 6'($random(seed));
		g1 = 6'($random(seed));
		b0 = 5'($random(seed));
		b1 = 5'($random(seed));
		thresh_low[c]  = {((r0 < r1) ? r0 : r1), ((g0 < g1) ? g0 : g1), ((b0 < b1) ? b0 : b1)};
		thresh_high[c] = {((r0 < r1) ? r1 : r0), ((g0 < g1) ? g1 : g0), ((b0 < b1) ? b1 : b0)};
	endtask

	task automatic run_frame(input int f);
		int                 accepted;
		int                 full_c;
		int                 empty_c;
		logic [COORD_W-1:0] mx;
		logic [COORD_W-1:0] my;
		full_c  = f % NUM_COLORS;
		empty_c = (f + 2) % NUM_COLORS;
		for (int c = 0; c < NUM_COLORS; c++) begin
			draw_window(c);
		end
		thresh_low[full_c]   = 16'h0000;        // Matches every pixel.
		thresh_high[full_c]  = 16'hffff;
		thresh_low[empty_c]  = 16'hffff;        // Low above high so it never matches.
		thresh_high[empty_c] = 16'h0000;
		model_clear();
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			pixel_valid = 1'b1;                 // No frame open yet.
			pixel       = 16'($random(seed));
		end
		next_cycle();
		if (frame_busy !== 1'b0) begin
			report_mismatch("frame_busy", 0, 32'(frame_busy));
			drv_errors++;
		end
		sof         = 1'b1;
		pixel       = 16'($random(seed));       // Arrives with sof and is dropped.
		accepted    = 0;
		mx          = '0;
		my          = '0;
		while (accepted < FRAME_PIX) begin
			next_cycle();
			sof = 1'b0;
			if (frame_busy !== 1'b1) begin
				report_mismatch("frame_busy", 1, 32'(frame_busy));
				drv_errors++;
			end
			pixel       = 16'($random(seed));
			pixel_valid = (($random(seed) & 3) != 0);
			if (pixel_valid) begin
				model_pixel(pixel, mx, my);
				accepted++;
				last_pix_cycle = cycle;
				if (mx == COORD_W'(FRAME_W - 1)) begin
					mx = '0;
					my = my + COORD_W'(1);
				end else begin
					mx = mx + COORD_W'(1);
				end
			end
		end
		// Through DRAIN and the five REPORT cycles any sof or strobe is ignored.
		for (int k = 0; k < NUM_COLORS + 1; k++) begin
			next_cycle();
			if (frame_busy !== 1'b1) begin
				report_mismatch("frame_busy", 1, 32'(frame_busy));
				drv_errors++;
			end
			sof         = (k == 3) || (($random(seed) & 1) != 0);
			pixel_valid = (($random(seed) & 1) != 0);
			pixel       = 16'($random(seed));
		end
		next_cycle();
		sof         = 1'b0;
		pixel_valid = 1'b0;
		while (frames_reported <= f) begin
			next_cycle();
		end
		if (frame_busy !== 1'b0) begin
			report_mismatch("frame_busy", 0, 32'(frame_busy));
			drv_errors++;
		end
	endtask

	// ==============================
	// Report monitor
	// ==============================
	task automatic check_result(input int c);
		if (result_color !== COLOR_IDX_W'(c)) begin
			report_mismatch("result_color", c, 32'(result_color));
			mon_errors++;
		end
		if (result_count !== exp_count[c]) begin
			report_mismatch("result_count", 32'(exp_count[c]), 32'(result_count));
			mon_errors++;
		end
		if (result_x_min !== exp_x_min[c]) begin
			report_mismatch("result_x_min", 32'(exp_x_min[c]), 32'(result_x_min));
			mon_errors++;
		end
		if (result_x_max !== exp_x_max[c]) begin
			report_mismatch("result_x_max", 32'(exp_x_max[c]), 32'(result_x_max));
			mon_errors++;
		end
		if (result_y_min !== exp_y_min[c]) begin
			report_mismatch("result_y_min", 32'(exp_y_min[c]), 32'(result_y_min));
			mon_errors++;
		end
		if (result_y_max !== exp_y_max[c]) begin
			report_mismatch("result_y_max", 32'(exp_y_max[c]), 32'(result_y_max));
			mon_errors++;
		end
		results_checked++;
	endtask

	// Results are sampled mid-cycle away from the clock edge and the input drive.
	always @(negedge clk) begin
		if (!rst) begin
			if (result_valid === 1'b1) begin
				if (rep_idx == 0 && cycle != last_pix_cycle + 2) begin
					report_mismatch("first result_valid cycle", last_pix_cycle + 2, cycle);
					mon_errors++;
				end
				if (frame_busy !== 1'b1) begin
					report_mismatch("frame_busy", 1, 32'(frame_busy));
					mon_errors++;
				end
				if (rep_idx >= NUM_COLORS) begin
					$display("** Error at %0t: more than %0d results in one report",
						$time, NUM_COLORS);
					mon_errors++;
				end else begin
					check_result(rep_idx);
				end
				rep_idx = rep_idx + 1;
			end else if (rep_idx != 0) begin
				if (rep_idx != NUM_COLORS) begin
					$display("** Error at %0t: report stopped after %0d results",
						$time, rep_idx);
					mon_errors++;
				end
				rep_idx         = 0;
				frames_reported = frames_reported + 1;
			end
		end
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		seed        = 32'h0219_b260;
		rst         = 1'b1;
		sof         = 1'b0;
		pixel_valid = 1'b0;
		pixel       = '0;
		thresh_high = '0;
		thresh_low  = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		if (result_valid !== 1'b0) begin
			report_mismatch("result_valid", 0, 32'(result_valid));
			drv_errors++;
		end
		if (frame_busy !== 1'b0) begin
			report_mismatch("frame_busy", 0, 32'(frame_busy));
			drv_errors++;
		end
		for (int f = 0; f < NUM_FRAMES; f++) begin
			run_frame(f);
		end
		repeat (4) next_cycle();
		$display("Frames: %0d, results checked: %0d, errors: %0d",
			frames_reported, results_checked, drv_errors + mon_errors);
		if (drv_errors + mon_errors == 0 && results_checked == NUM_FRAMES * NUM_COLORS) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
rtl/blob_pkg.sv
rtl/pixel_tag_if.sv
rtl/color_thresholds.sv
rtl/pixel_position_counter.sv
rtl/frame_sequencer.sv
rtl/color_region_tracker.sv
rtl/color_blob_detector.sv
verif/tb_color_blob_detector.sv

//--- Makefile
# Verilator build and run for the color blob detector.
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_color_blob_detector
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
